// File: sources.f
+incdir+common
common/snoop_trace_pkg.sv
common/snoop_ctrl_pkg.sv
common/snoop_trace_if.sv
common/snoop_cfg_if.sv
snooper/snoop_cfg_regs.sv
snooper/trace_select.sv
snooper/snoop_capture_fsm.sv
snooper/trace_fifo.sv
snooper/fifo_fill_counter.sv
logic/trace_snooper_top.sv
verif/trace_snooper_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the snooper testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps \
  --top-module trace_snooper_tb \
  -f sources.f -o trace_snooper_sim

out=$(./obj_dir/trace_snooper_sim)
echo "$out"

# Fails the script unless the pass line was printed
echo "$out" | grep -q "SIMULATION PASSED"

// File: verif/trace_snooper_tb.sv
// --------------------------------------------------
// Table-driven testbench, FIFO is drained after every test
// Trigger address goes in before the trigger test rows
// --------------------------------------------------
`timescale 1ns/1ps
`include "snoop_settings.svh"

module trace_snooper_tb;

  localparam int NUM_ROWS   = 17;
  localparam int WATERMARK  = 24;
  localparam int WAIT_LIMIT = 20;

  // One table row, addresses and opcode filled from the LCG
  typedef struct packed {
    int          test;
    int          gap;
    logic        core;
    logic [1:0]  ctrl;
    logic        accept;
    logic        trig;
    logic [3:0]  ctr;
    logic [1:0]  priv;
    logic [63:0] src;
    logic [63:0] dst;
    logic [31:0] opcode;
  } row_t;

  logic                                                      clk_i;
  logic                                                      reset_i;
  logic [`SNOOP_NUM_CORES-1:0]                               trace_valid_i;
  snoop_trace_pkg::priv_lvl_t [`SNOOP_NUM_CORES-1:0]         priv_lvl_i;
  snoop_trace_pkg::ctr_type_t [`SNOOP_NUM_CORES-1:0]         ctr_type_i;
  logic [`SNOOP_NUM_CORES-1:0][`SNOOP_PC_WIDTH-1:0]          pc_src_i;
  logic [`SNOOP_NUM_CORES-1:0][`SNOOP_PC_WIDTH-1:0]          pc_dst_i;
  logic [`SNOOP_NUM_CORES-1:0][`SNOOP_WORD_WIDTH-1:0]        opcode_i;
  logic                                                      cfg_we_i;
  snoop_ctrl_pkg::cfg_addr_t                                 cfg_addr_i;
  logic [`SNOOP_WORD_WIDTH-1:0]                              cfg_wdata_i;
  logic                                                      pop_i;
  logic [`SNOOP_WORD_WIDTH-1:0]                              trace_word_o;
  logic                                                      empty_o;
  logic                                                      watermark_irq_o;
  logic                                                      trigger_irq_o;

  logic [31:0] lcg_state;
  row_t        rows [NUM_ROWS];
  int          num_rows;
  int          trig_row;
  logic [31:0] model_q [$];
  int          checks;
  int          errors;
  int          trig_seen;
  logic [1:0]  ctrl_now;

  trace_snooper_top DUT (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .trace_valid_i   ( trace_valid_i   ),
    .priv_lvl_i      ( priv_lvl_i      ),
    .ctr_type_i      ( ctr_type_i      ),
    .pc_src_i        ( pc_src_i        ),
    .pc_dst_i        ( pc_dst_i        ),
    .opcode_i        ( opcode_i        ),
    .cfg_we_i        ( cfg_we_i        ),
    .cfg_addr_i      ( cfg_addr_i      ),
    .cfg_wdata_i     ( cfg_wdata_i     ),
    .pop_i           ( pop_i           ),
    .trace_word_o    ( trace_word_o    ),
    .empty_o         ( empty_o         ),
    .watermark_irq_o ( watermark_irq_o ),
    .trigger_irq_o   ( trigger_irq_o   )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Pulse is one cycle wide, so one negedge sees it
  always @(negedge clk_i) begin
    if (trigger_irq_o) begin
      trig_seen <= trig_seen + 1;
    end
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic string test_name(input int t);
    case (t)
      1:       return "record format";
      2:       return "core select";
      3:       return "busy drop";
      4:       return "watermark and room";
      default: return "trigger";
    endcase
  endfunction

  task automatic compare_values(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
    end
  endtask

  task automatic add_row(input int test, input logic core, input logic [1:0] ctrl,
                         input int gap, input logic accept, input logic trig);
    row_t        r;
    logic [31:0] rnd;
    rnd      = next_random();
    r.test   = test;
    r.gap    = gap;
    r.core   = core;
    r.ctrl   = ctrl;
    r.accept = accept;
    r.trig   = trig;
    r.ctr    = rnd[3:0];
    r.priv   = rnd[5:4];
    r.src    = {next_random(), next_random()};
    r.dst    = {next_random(), next_random()};
    r.opcode = next_random();
    rows[num_rows] = r;
    num_rows++;
  endtask

  // --------------------------------------------------
  // Stimulus table: test, core, ctrl, gap, accept, trigger
  // --------------------------------------------------
  task automatic build_table();
    add_row(1, 1'b0, 2'd0, 8, 1'b1, 1'b0);
    // Core 1 selected
    add_row(2, 1'b0, 2'd1, 8, 1'b0, 1'b0);
    add_row(2, 1'b1, 2'd1, 8, 1'b1, 1'b0);
    add_row(2, 1'b0, 2'd1, 8, 1'b0, 1'b0);
    add_row(2, 1'b1, 2'd1, 7, 1'b1, 1'b0);
    // Second row lands mid-record
    add_row(3, 1'b0, 2'd0, 8, 1'b1, 1'b0);
    add_row(3, 1'b0, 2'd0, 3, 1'b0, 1'b0);
    add_row(3, 1'b0, 2'd0, 7, 1'b1, 1'b0);
    // Fifth record fits in 32 words, sixth does not
    add_row(4, 1'b0, 2'd0, 7, 1'b1, 1'b0);
    add_row(4, 1'b0, 2'd0, 7, 1'b1, 1'b0);
    add_row(4, 1'b0, 2'd0, 7, 1'b1, 1'b0);
    add_row(4, 1'b0, 2'd0, 7, 1'b1, 1'b0);
    add_row(4, 1'b0, 2'd0, 7, 1'b1, 1'b0);
    add_row(4, 1'b0, 2'd0, 7, 1'b0, 1'b0);
    trig_row = num_rows;
    add_row(5, 1'b0, 2'd2, 8, 1'b1, 1'b1);
    add_row(5, 1'b0, 2'd2, 8, 1'b1, 1'b0);
    add_row(5, 1'b0, 2'd0, 8, 1'b1, 1'b0);
    // Disabled row reuses the trigger address
    rows[trig_row + 2].dst = rows[trig_row].dst;
  endtask

  task automatic push_record(input row_t r);
    model_q.push_back({`SNOOP_HEADER_MARK, 15'd0, r.core, r.priv, 2'b00, r.ctr});
    model_q.push_back({1'b0, r.src[62:32]});
    model_q.push_back({r.src[31:1], 1'b0});
    model_q.push_back({1'b0, r.dst[62:32]});
    model_q.push_back({r.dst[31:1], 1'b0});
    model_q.push_back(r.opcode);
  endtask

  task automatic write_cfg(input snoop_ctrl_pkg::cfg_addr_t addr, input logic [31:0] data);
    @(posedge clk_i);
    cfg_we_i    <= 1'b1;
    cfg_addr_i  <= addr;
    cfg_wdata_i <= data;
    @(posedge clk_i);
    cfg_we_i    <= 1'b0;
  endtask

  // Row is sampled gap edges after the previous row
  task automatic apply_row(input row_t r);
    if (r.ctrl != ctrl_now) begin
      write_cfg(snoop_ctrl_pkg::CTRL, {30'd0, r.ctrl});
      ctrl_now = r.ctrl;
    end
    repeat (r.gap - 1) @(posedge clk_i);
    trace_valid_i[r.core] <= 1'b1;
    priv_lvl_i[r.core]    <= r.priv;
    ctr_type_i[r.core]    <= r.ctr;
    pc_src_i[r.core]      <= r.src;
    pc_dst_i[r.core]      <= r.dst;
    opcode_i[r.core]      <= r.opcode;
    @(posedge clk_i);
    trace_valid_i <= '0;
  endtask

  task automatic drain_fifo(output logic ok);
    logic [31:0]                  exp_word;
    snoop_trace_pkg::trace_word_u hdr;
    logic                         is_header;
    int                           waited;
    ok = 1'b1;
    while (ok && model_q.size() > 0) begin
      is_header = (model_q.size() % `SNOOP_WORDS_PER_RECORD == 0);
      waited = 0;
      @(negedge clk_i);
      while (empty_o && waited < WAIT_LIMIT) begin
        @(negedge clk_i);
        waited++;
      end
      if (empty_o) begin
        $display("Timeout: FIFO stayed empty with %0d words still expected", model_q.size());
        ok = 1'b0;
      end else begin
        // Level before this pop
        compare_values("watermark_irq_o", 64'(watermark_irq_o),
                       64'(model_q.size() >= WATERMARK));
        exp_word = model_q.pop_front();
        if (is_header) begin
          hdr.data = trace_word_o;
          compare_values("header.mark", 64'(hdr.header.mark), 64'(`SNOOP_HEADER_MARK));
        end
        compare_values("trace_word_o", 64'(trace_word_o), 64'(exp_word));
        @(posedge clk_i);
        pop_i <= 1'b1;
        @(posedge clk_i);
        pop_i <= 1'b0;
      end
    end
    if (ok) begin
      @(negedge clk_i);
      // Extra words would keep the FIFO non-empty
      compare_values("empty_o", 64'(empty_o), 64'(1'b1));
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    int   t;
    int   i;
    int   err_base;
    int   trig_base;
    int   trig_exp;
    logic ok;
    logic timed_out;
    lcg_state = 32'h6083dc4e;
    checks    = 0;
    errors    = 0;
    timed_out = 1'b0;
    ctrl_now  = 2'd0;
    reset_i       <= 1'b1;
    trace_valid_i <= '0;
    priv_lvl_i    <= '0;
    ctr_type_i    <= '0;
    pc_src_i      <= '0;
    pc_dst_i      <= '0;
    opcode_i      <= '0;
    cfg_we_i      <= 1'b0;
    cfg_addr_i    <= snoop_ctrl_pkg::CTRL;
    cfg_wdata_i   <= '0;
    pop_i         <= 1'b0;
    build_table();
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;

    for (t = 1; t <= 5; t++) begin
      err_base  = errors;
      trig_base = trig_seen;
      trig_exp  = 0;
      if (t == 1) begin
        @(negedge clk_i);
        compare_values("empty_o", 64'(empty_o), 64'(1'b1));
        compare_values("watermark_irq_o", 64'(watermark_irq_o), 64'(1'b0));
        compare_values("trigger_irq_o", 64'(trigger_irq_o), 64'(1'b0));
      end
      if (t == 5) begin
        write_cfg(snoop_ctrl_pkg::TRIG_LO, rows[trig_row].dst[31:0]);
        write_cfg(snoop_ctrl_pkg::TRIG_HI, rows[trig_row].dst[63:32]);
      end
      for (i = 0; i < num_rows; i++) begin
        if (rows[i].test == t) begin
          apply_row(rows[i]);
          if (rows[i].accept) begin
            push_record(rows[i]);
          end
          if (rows[i].trig) begin
            trig_exp++;
          end
        end
      end
      // Last record is complete six edges after its accept
      repeat (8) @(posedge clk_i);
      drain_fifo(ok);
      compare_values("trigger_irq_o pulses", 64'(trig_seen - trig_base), 64'(trig_exp));
      $display("test %0d %s: %0d mismatches%s", t, test_name(t), errors - err_base,
               ok ? "" : ", timed out");
      if (!ok) begin
        timed_out = 1'b1;
        break;
      end
    end

    $display("checks=%0d errors=%0d timeout=%0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: logic/trace_snooper_top.sv
// ------------------------------------------------
// Single clock domain, plain register and pop ports
// Traces that arrive while busy or without room are lost
// ------------------------------------------------
`timescale 1ns/1ps
`include "snoop_settings.svh"

module trace_snooper_top (
  input  logic                                               clk_i,
  input  logic                                               reset_i,
  // Per-core trace ports
  input  logic [`SNOOP_NUM_CORES-1:0]                        trace_valid_i,
  input  snoop_trace_pkg::priv_lvl_t [`SNOOP_NUM_CORES-1:0]  priv_lvl_i,
  input  snoop_trace_pkg::ctr_type_t [`SNOOP_NUM_CORES-1:0]  ctr_type_i,
  input  logic [`SNOOP_NUM_CORES-1:0][`SNOOP_PC_WIDTH-1:0]   pc_src_i,
  input  logic [`SNOOP_NUM_CORES-1:0][`SNOOP_PC_WIDTH-1:0]   pc_dst_i,
  input  logic [`SNOOP_NUM_CORES-1:0][`SNOOP_WORD_WIDTH-1:0] opcode_i,
  // Register write port
  input  logic                                               cfg_we_i,
  input  snoop_ctrl_pkg::cfg_addr_t                          cfg_addr_i,
  input  logic [`SNOOP_WORD_WIDTH-1:0]                       cfg_wdata_i,
  // Word read port
  input  logic                                               pop_i,
  output logic [`SNOOP_WORD_WIDTH-1:0]                       trace_word_o,
  output logic                                               empty_o,
  // Interrupts
  output logic                                               watermark_irq_o,
  output logic                                               trigger_irq_o
);

  logic                        push;
  snoop_trace_pkg::trace_word_u wdata;
  logic                        room;
  logic                        pop_accept;

  snoop_trace_if trace_if ();
  snoop_cfg_if   cfg_if ();

  snoop_cfg_regs i_cfg_regs (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg         ( cfg_if      )
  );

  trace_select i_trace_select (
    .trace_valid_i ( trace_valid_i ),
    .priv_lvl_i    ( priv_lvl_i    ),
    .ctr_type_i    ( ctr_type_i    ),
    .pc_src_i      ( pc_src_i      ),
    .pc_dst_i      ( pc_dst_i      ),
    .opcode_i      ( opcode_i      ),
    .cfg           ( cfg_if        ),
    .trace         ( trace_if      )
  );

  snoop_capture_fsm i_capture (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .trace         ( trace_if      ),
    .cfg           ( cfg_if        ),
    .room_i        ( room          ),
    .push_o        ( push          ),
    .wdata_o       ( wdata         ),
    .trigger_irq_o ( trigger_irq_o )
  );

  fifo_fill_counter i_fill_counter (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .push_i          ( push            ),
    .pop_i           ( pop_i           ),
    .cfg             ( cfg_if          ),
    .pop_accept_o    ( pop_accept      ),
    .empty_o         ( empty_o         ),
    .room_o          ( room            ),
    .watermark_irq_o ( watermark_irq_o )
  );

  trace_fifo i_trace_fifo (
    .clk_i   ( clk_i        ),
    .reset_i ( reset_i      ),
    .push_i  ( push         ),
    .wdata_i ( wdata        ),
    .pop_i   ( pop_accept   ),
    .rdata_o ( trace_word_o )
  );

endmodule

// File: snooper/fifo_fill_counter.sv
// ------------------------------------------------
// Word count and the flags derived from it
// ------------------------------------------------
`timescale 1ns/1ps
`include "snoop_settings.svh"

module fifo_fill_counter (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       push_i,
  input  logic       pop_i,
  snoop_cfg_if.level cfg,
  output logic       pop_accept_o,
  output logic       empty_o,
  output logic       room_o,
  output logic       watermark_irq_o
);

  logic [`SNOOP_COUNT_WIDTH-1:0] count_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else begin
      case ({push_i, pop_accept_o})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign empty_o      = (count_q == '0);
  // Pops while empty are ignored
  assign pop_accept_o = pop_i && !empty_o;
  // Room for one whole record
  assign room_o = (int'(count_q) + `SNOOP_WORDS_PER_RECORD) <= `SNOOP_FIFO_DEPTH;
  assign watermark_irq_o = (count_q >= cfg.watermark);

endmodule

// File: snooper/trace_fifo.sv
// ------------------------------------------------
// First-word-fall-through word store, no full check
// Caller must gate push by room and pop by empty
// ------------------------------------------------
`timescale 1ns/1ps
`include "snoop_settings.svh"

module trace_fifo (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         push_i,
  input  snoop_trace_pkg::trace_word_u wdata_i,
  input  logic                         pop_i,
  output logic [`SNOOP_WORD_WIDTH-1:0] rdata_o
);

  logic [`SNOOP_WORD_WIDTH-1:0] mem [`SNOOP_FIFO_DEPTH];
  logic [`SNOOP_PTR_WIDTH-1:0]  wr_ptr_q;
  logic [`SNOOP_PTR_WIDTH-1:0]  rd_ptr_q;

  // Pointers wrap at the power-of-two depth
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= wdata_i.data;
    end
  end

  // Head word, valid whenever the FIFO is not empty
  assign rdata_o = mem[rd_ptr_q];

endmodule

// File: snooper/snoop_capture_fsm.sv
// ------------------------------------------------
// Takes a trace only when idle with room for a record
// Anything else is dropped, there is no back-pressure
// ------------------------------------------------
`timescale 1ns/1ps
`include "snoop_settings.svh"

module snoop_capture_fsm (
  input  logic                        clk_i,
  input  logic                        reset_i,
  snoop_trace_if.dst                  trace,
  snoop_cfg_if.trig                   cfg,
  input  logic                        room_i,
  output logic                        push_o,
  output snoop_trace_pkg::trace_word_u wdata_o,
  output logic                        trigger_irq_o
);

  snoop_ctrl_pkg::capture_state_t state_q;
  snoop_ctrl_pkg::capture_state_t state_d;
  logic                           accept;
  logic                           trig_hit;
  logic                           trigger_q;

  // Latched record payload
  logic                           rec_core_q;
  snoop_trace_pkg::priv_lvl_t     rec_priv_q;
  snoop_trace_pkg::ctr_type_t     rec_type_q;
  logic [`SNOOP_WORD_WIDTH-1:0]   rec_src_hi_q;
  logic [`SNOOP_WORD_WIDTH-1:0]   rec_src_lo_q;
  logic [`SNOOP_WORD_WIDTH-1:0]   rec_dst_hi_q;
  logic [`SNOOP_WORD_WIDTH-1:0]   rec_dst_lo_q;
  logic [`SNOOP_WORD_WIDTH-1:0]   rec_opcode_q;

  assign accept = (state_q == snoop_ctrl_pkg::IDLE) && trace.valid && room_i;

  // ------------------------------------------------
  // Record sequencing
  // ------------------------------------------------
  always_comb begin
    case (state_q)
      snoop_ctrl_pkg::IDLE:   state_d = accept ? snoop_ctrl_pkg::HEADER : snoop_ctrl_pkg::IDLE;
      snoop_ctrl_pkg::HEADER: state_d = snoop_ctrl_pkg::SRC_HI;
      snoop_ctrl_pkg::SRC_HI: state_d = snoop_ctrl_pkg::SRC_LO;
      snoop_ctrl_pkg::SRC_LO: state_d = snoop_ctrl_pkg::DST_HI;
      snoop_ctrl_pkg::DST_HI: state_d = snoop_ctrl_pkg::DST_LO;
      snoop_ctrl_pkg::DST_LO: state_d = snoop_ctrl_pkg::OPCODE;
      default:                state_d = snoop_ctrl_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= snoop_ctrl_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rec_core_q   <= trace.core_id;
      rec_priv_q   <= trace.priv_lvl;
      rec_type_q   <= trace.ctr_type;
      rec_src_hi_q <= trace.src_hi;
      rec_src_lo_q <= trace.src_lo;
      rec_dst_hi_q <= trace.dst_hi;
      rec_dst_lo_q <= trace.dst_lo;
      rec_opcode_q <= trace.opcode;
    end
  end

  // One word per busy state
  always_comb begin
    wdata_o = '0;
    push_o  = 1'b1;
    case (state_q)
      snoop_ctrl_pkg::HEADER: begin
        wdata_o.header.mark     = `SNOOP_HEADER_MARK;
        wdata_o.header.core_id  = rec_core_q;
        wdata_o.header.priv_lvl = rec_priv_q;
        wdata_o.header.ctr_type = rec_type_q;
      end
      snoop_ctrl_pkg::SRC_HI: wdata_o.data = rec_src_hi_q;
      snoop_ctrl_pkg::SRC_LO: wdata_o.data = rec_src_lo_q;
      snoop_ctrl_pkg::DST_HI: wdata_o.data = rec_dst_hi_q;
      snoop_ctrl_pkg::DST_LO: wdata_o.data = rec_dst_lo_q;
      snoop_ctrl_pkg::OPCODE: wdata_o.data = rec_opcode_q;
      default:                push_o       = 1'b0;
    endcase
  end

  // ------------------------------------------------
  // Trigger, checked on every valid trace
  // ------------------------------------------------
  // Trigger address goes through the same packing as the trace
  assign trig_hit =
      (trace.dst_hi == {1'b0, cfg.trig_pc[`SNOOP_PC_WIDTH-2:`SNOOP_WORD_WIDTH]}) &&
      (trace.dst_lo == {cfg.trig_pc[`SNOOP_WORD_WIDTH-1:1], 1'b0});

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      trigger_q <= 1'b0;
    end else begin
      trigger_q <= trace.valid && cfg.trig_en && trig_hit;
    end
  end

  assign trigger_irq_o = trigger_q;

endmodule

// File: snooper/trace_select.sv
// ------------------------------------------------
// Purely combinational core select
// PC bit 63 and bit 0 are dropped by the packing
// ------------------------------------------------
`timescale 1ns/1ps
`include "snoop_settings.svh"

module trace_select (
  input  logic [`SNOOP_NUM_CORES-1:0]                        trace_valid_i,
  input  snoop_trace_pkg::priv_lvl_t [`SNOOP_NUM_CORES-1:0]  priv_lvl_i,
  input  snoop_trace_pkg::ctr_type_t [`SNOOP_NUM_CORES-1:0]  ctr_type_i,
  input  logic [`SNOOP_NUM_CORES-1:0][`SNOOP_PC_WIDTH-1:0]   pc_src_i,
  input  logic [`SNOOP_NUM_CORES-1:0][`SNOOP_PC_WIDTH-1:0]   pc_dst_i,
  input  logic [`SNOOP_NUM_CORES-1:0][`SNOOP_WORD_WIDTH-1:0] opcode_i,
  snoop_cfg_if.sel                                           cfg,
  snoop_trace_if.src                                         trace
);

  logic [`SNOOP_PC_WIDTH-1:0] src_pc;
  logic [`SNOOP_PC_WIDTH-1:0] dst_pc;

  assign src_pc = pc_src_i[cfg.core_sel];
  assign dst_pc = pc_dst_i[cfg.core_sel];

  assign trace.valid    = trace_valid_i[cfg.core_sel];
  assign trace.core_id  = cfg.core_sel;
  assign trace.priv_lvl = priv_lvl_i[cfg.core_sel];
  assign trace.ctr_type = ctr_type_i[cfg.core_sel];
  assign trace.opcode   = opcode_i[cfg.core_sel];

  // High word keeps bits 62..32, low word clears bit 0
  assign trace.src_hi = {1'b0, src_pc[`SNOOP_PC_WIDTH-2:`SNOOP_WORD_WIDTH]};
  assign trace.src_lo = {src_pc[`SNOOP_WORD_WIDTH-1:1], 1'b0};
  assign trace.dst_hi = {1'b0, dst_pc[`SNOOP_PC_WIDTH-2:`SNOOP_WORD_WIDTH]};
  assign trace.dst_lo = {dst_pc[`SNOOP_WORD_WIDTH-1:1], 1'b0};

endmodule

// File: snooper/snoop_cfg_regs.sv
// ------------------------------------------------
// Write-only registers, no read back
// A write is visible the cycle after the strobe edge
// ------------------------------------------------
`timescale 1ns/1ps
`include "snoop_settings.svh"

module snoop_cfg_regs (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         cfg_we_i,
  input  snoop_ctrl_pkg::cfg_addr_t    cfg_addr_i,
  input  logic [`SNOOP_WORD_WIDTH-1:0] cfg_wdata_i,
  snoop_cfg_if.regs                    cfg
);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg.core_sel  <= 1'b0;
      cfg.trig_en   <= 1'b0;
      cfg.trig_pc   <= '0;
      cfg.watermark <= `SNOOP_DEFAULT_WATERMARK;
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        snoop_ctrl_pkg::CTRL: begin
          cfg.core_sel <= cfg_wdata_i[0];
          cfg.trig_en  <= cfg_wdata_i[1];
        end
        snoop_ctrl_pkg::WATERMARK: begin
          // Upper bits beyond the count width are ignored
          cfg.watermark <= cfg_wdata_i[`SNOOP_COUNT_WIDTH-1:0];
        end
        // Trigger address arrives as two halves
        snoop_ctrl_pkg::TRIG_LO: begin
          cfg.trig_pc[`SNOOP_WORD_WIDTH-1:0] <= cfg_wdata_i;
        end
        snoop_ctrl_pkg::TRIG_HI: begin
          cfg.trig_pc[`SNOOP_PC_WIDTH-1:`SNOOP_WORD_WIDTH] <= cfg_wdata_i;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// File: common/snoop_cfg_if.sv
// ------------------------------------------------
// Configuration register values to their consumers
// ------------------------------------------------
`timescale 1ns/1ps
`include "snoop_settings.svh"

interface snoop_cfg_if;
  logic                          core_sel;
  logic                          trig_en;
  logic [`SNOOP_PC_WIDTH-1:0]    trig_pc;
  logic [`SNOOP_COUNT_WIDTH-1:0] watermark;

  modport regs (output core_sel, trig_en, trig_pc, watermark);
  // Core multiplexer
  modport sel (input core_sel);
  // Trigger compare in the capture machine
  modport trig (input trig_en, trig_pc);
  // Fill level watermark
  modport level (input watermark);
endinterface

// File: common/snoop_trace_if.sv
// ------------------------------------------------
// Selected trace, already packed into 32-bit words
// ------------------------------------------------
`timescale 1ns/1ps
`include "snoop_settings.svh"

interface snoop_trace_if;
  logic                         valid;
  logic                         core_id;
  snoop_trace_pkg::priv_lvl_t   priv_lvl;
  snoop_trace_pkg::ctr_type_t   ctr_type;
  logic [`SNOOP_WORD_WIDTH-1:0] src_hi;
  logic [`SNOOP_WORD_WIDTH-1:0] src_lo;
  logic [`SNOOP_WORD_WIDTH-1:0] dst_hi;
  logic [`SNOOP_WORD_WIDTH-1:0] dst_lo;
  logic [`SNOOP_WORD_WIDTH-1:0] opcode;

  modport src (output valid, core_id, priv_lvl, ctr_type,
               src_hi, src_lo, dst_hi, dst_lo, opcode);
  modport dst (input valid, core_id, priv_lvl, ctr_type,
               src_hi, src_lo, dst_hi, dst_lo, opcode);
endinterface

// File: common/snoop_ctrl_pkg.sv
// ------------------------------------------------
// Capture states and configuration addresses
// ------------------------------------------------
package snoop_ctrl_pkg;

  // One state per record word, in write order
  typedef enum logic [2:0] {
    IDLE, HEADER, SRC_HI, SRC_LO, DST_HI, DST_LO, OPCODE
  } capture_state_t;

  // CTRL bit 0 selects the core, bit 1 enables the trigger
  typedef enum logic [1:0] {
    CTRL = 2'd0, WATERMARK = 2'd1, TRIG_LO = 2'd2, TRIG_HI = 2'd3
  } cfg_addr_t;

endpackage

// File: common/snoop_trace_pkg.sv
// ------------------------------------------------
// Trace field types and the FIFO word layout
// Header word is the first word of every six-word record
// ------------------------------------------------
`include "snoop_settings.svh"

package snoop_trace_pkg;

  typedef logic [1:0] priv_lvl_t;
  typedef logic [3:0] ctr_type_t;
  typedef logic [`SNOOP_WORD_WIDTH-1:0] trace_data_t;

  // Header layout, MSB first, 32 bits in total
  typedef struct packed {
    logic [7:0]  mark;
    logic [14:0] zero;
    logic        core_id;
    priv_lvl_t   priv_lvl;
    logic [1:0]  pad;
    ctr_type_t   ctr_type;
  } trace_header_t;

  // One FIFO word, seen as a header or as plain data
  typedef union packed {
    trace_header_t header;
    trace_data_t   data;
  } trace_word_u;

endpackage

// File: common/snoop_settings.svh
// ------------------------------------------------
// Sizes shared by every snooper block
// FIFO depth must be a power of two; pointers wrap naturally
// Count width must hold the depth itself (0..DEPTH)
// ------------------------------------------------
`ifndef SNOOP_SETTINGS_SVH
`define SNOOP_SETTINGS_SVH

`define SNOOP_NUM_CORES          2
`define SNOOP_PC_WIDTH           64
`define SNOOP_WORD_WIDTH         32
`define SNOOP_FIFO_DEPTH         32
`define SNOOP_PTR_WIDTH          5
`define SNOOP_COUNT_WIDTH        6
`define SNOOP_WORDS_PER_RECORD   6
`define SNOOP_DEFAULT_WATERMARK  6'd24
`define SNOOP_HEADER_MARK        8'hA5

`endif
